// ==== common/s1c88_settings.svh ====
`ifndef S1C88_SETTINGS_SVH
`define S1C88_SETTINGS_SVH

// external bus widths
`define S1C88_ADDR_W 24
`define S1C88_DATA_W 8

`define S1C88_PC_W 16

// microcode address width and the number of words actually used
`define S1C88_UPC_W 5
`define S1C88_UCODE_DEPTH 15

// low byte of the reset vector, the high byte follows it
`define S1C88_RESET_VECTOR 0

`endif

// ==== common/s1c88_pkg.sv ====
`default_nettype none

`include "s1c88_settings.svh"

package s1c88_pkg;

    // bus_status codes
    typedef enum logic [1:0]
    {
        BUS_IDLE      = 2'd0,
        BUS_MEM_WRITE = 2'd2,
        BUS_MEM_READ  = 2'd3
    } bus_cmd_t;

    typedef enum logic [1:0]
    {
        ALU_PASS = 2'd0,
        ALU_AND  = 2'd1,
        ALU_OR   = 2'd2,
        ALU_XOR  = 2'd3
    } alu_op_t;

    // zero in every field gives a blank internal step
    typedef enum logic [2:0]
    {
        UOP_INT = 3'd0,
        UOP_RD  = 3'd1,
        UOP_WR  = 3'd2
    } uop_kind_t;

    typedef enum logic [1:0]
    {
        ADDR_PC  = 2'd0,
        ADDR_BRP = 2'd1
    } uop_addr_t;

    typedef enum logic [2:0]
    {
        SRC_IMM = 3'd0,
        SRC_A   = 3'd1,
        SRC_ALU = 3'd2,
        SRC_RD  = 3'd3
    } uop_src_t;

    typedef enum logic [2:0]
    {
        DST_NONE = 3'd0,
        DST_A    = 3'd1,
        DST_BR   = 3'd2,
        DST_AA   = 3'd3,
        DST_AB   = 3'd4
    } uop_dst_t;

    typedef struct packed
    {
        uop_kind_t kind;
        uop_addr_t addr_sel;
        uop_src_t  src;
        uop_dst_t  dst;
        alu_op_t   alu_op;
        logic      last;
    } micro_op_t;

    typedef struct packed
    {
        bus_cmd_t                 cmd;
        logic [`S1C88_ADDR_W-1:0] address;
        logic [`S1C88_DATA_W-1:0] wdata;
    } bus_req_t;

endpackage

`default_nettype wire

// ==== cpu/s1c88_microcode_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s1c88_settings.svh"

module s1c88_microcode_rom
(
    input  wire logic [`S1C88_DATA_W-1:0] opcode,
    input  wire logic [`S1C88_UPC_W-1:0]  uaddr,
    output logic [`S1C88_UPC_W-1:0]       start_uaddr,
    output s1c88_pkg::micro_op_t          uop
);

    function automatic s1c88_pkg::micro_op_t make_uop
    (
        input s1c88_pkg::uop_kind_t kind,
        input s1c88_pkg::uop_addr_t addr_sel,
        input s1c88_pkg::uop_src_t  src,
        input s1c88_pkg::uop_dst_t  dst,
        input s1c88_pkg::alu_op_t   alu_op,
        input logic                 last
    );
        s1c88_pkg::micro_op_t op;
        op.kind = kind;
        op.addr_sel = addr_sel;
        op.src = src;
        op.dst = dst;
        op.alu_op = alu_op;
        op.last = last;
        return op;
    endfunction

    // translation table, anything unlisted runs the no-op at 0
    always_comb
    begin
        case (opcode)
            8'hB4:   start_uaddr = 5'd1;
            8'h44:   start_uaddr = 5'd2;
            8'h45:   start_uaddr = 5'd3;
            8'hDD:   start_uaddr = 5'd4;
            8'hD8:   start_uaddr = 5'd6;
            8'hD9:   start_uaddr = 5'd9;
            8'hDA:   start_uaddr = 5'd12;
            default: start_uaddr = 5'd0;
        endcase
    end

    // ll comes from the immediate read, #nn is fetched by the first micro step
    always_comb
    begin
        case (uaddr)
            5'd1:
                uop = make_uop(s1c88_pkg::UOP_INT, s1c88_pkg::ADDR_PC, s1c88_pkg::SRC_IMM,
                               s1c88_pkg::DST_BR, s1c88_pkg::ALU_PASS, 1'b1);
            5'd2:
                uop = make_uop(s1c88_pkg::UOP_RD, s1c88_pkg::ADDR_BRP, s1c88_pkg::SRC_RD,
                               s1c88_pkg::DST_A, s1c88_pkg::ALU_PASS, 1'b1);
            5'd3:
                uop = make_uop(s1c88_pkg::UOP_WR, s1c88_pkg::ADDR_BRP, s1c88_pkg::SRC_A,
                               s1c88_pkg::DST_NONE, s1c88_pkg::ALU_PASS, 1'b1);
            5'd4, 5'd6, 5'd9, 5'd12:
                uop = make_uop(s1c88_pkg::UOP_RD, s1c88_pkg::ADDR_PC, s1c88_pkg::SRC_RD,
                               s1c88_pkg::DST_AB, s1c88_pkg::ALU_PASS, 1'b0);
            5'd5:
                uop = make_uop(s1c88_pkg::UOP_WR, s1c88_pkg::ADDR_BRP, s1c88_pkg::SRC_ALU,
                               s1c88_pkg::DST_NONE, s1c88_pkg::ALU_PASS, 1'b1);
            5'd7, 5'd10, 5'd13:
                uop = make_uop(s1c88_pkg::UOP_RD, s1c88_pkg::ADDR_BRP, s1c88_pkg::SRC_RD,
                               s1c88_pkg::DST_AA, s1c88_pkg::ALU_PASS, 1'b0);
            // read-modify-write result goes back to the same page address
            5'd8:
                uop = make_uop(s1c88_pkg::UOP_WR, s1c88_pkg::ADDR_BRP, s1c88_pkg::SRC_ALU,
                               s1c88_pkg::DST_NONE, s1c88_pkg::ALU_AND, 1'b1);
            5'd11:
                uop = make_uop(s1c88_pkg::UOP_WR, s1c88_pkg::ADDR_BRP, s1c88_pkg::SRC_ALU,
                               s1c88_pkg::DST_NONE, s1c88_pkg::ALU_OR, 1'b1);
            5'd14:
                uop = make_uop(s1c88_pkg::UOP_WR, s1c88_pkg::ADDR_BRP, s1c88_pkg::SRC_ALU,
                               s1c88_pkg::DST_NONE, s1c88_pkg::ALU_XOR, 1'b1);
            default:
                uop = make_uop(s1c88_pkg::UOP_INT, s1c88_pkg::ADDR_PC, s1c88_pkg::SRC_IMM,
                               s1c88_pkg::DST_NONE, s1c88_pkg::ALU_PASS, 1'b1);
        endcase
    end

endmodule

`default_nettype wire

// ==== cpu/s1c88_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s1c88_settings.svh"

module s1c88_datapath
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire s1c88_pkg::micro_op_t     exec_uop,
    input  wire logic                     step_done,
    input  wire logic [`S1C88_DATA_W-1:0] rdata,
    input  wire logic [`S1C88_DATA_W-1:0] imm,
    output logic [`S1C88_DATA_W-1:0]      br,
    output logic [`S1C88_DATA_W-1:0]      wdata
);

    logic [`S1C88_DATA_W-1:0] a_reg;
    logic [`S1C88_DATA_W-1:0] br_reg;
    logic [`S1C88_DATA_W-1:0] alu_a;
    logic [`S1C88_DATA_W-1:0] alu_b;
    logic [`S1C88_DATA_W-1:0] alu_r;
    logic [`S1C88_DATA_W-1:0] src_val;

    always_comb
    begin
        case (exec_uop.alu_op)
            s1c88_pkg::ALU_AND: alu_r = alu_a & alu_b;
            s1c88_pkg::ALU_OR:  alu_r = alu_a | alu_b;
            s1c88_pkg::ALU_XOR: alu_r = alu_a ^ alu_b;
            default:            alu_r = alu_b;
        endcase
    end

    always_comb
    begin
        case (exec_uop.src)
            s1c88_pkg::SRC_A:   src_val = a_reg;
            s1c88_pkg::SRC_ALU: src_val = alu_r;
            s1c88_pkg::SRC_RD:  src_val = rdata;
            default:            src_val = imm;
        endcase
    end

    // same selection feeds the write cycle
    assign wdata = src_val;
    assign br = br_reg;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            a_reg  <= '0;
            br_reg <= '0;
        end
        else if (step_done)
        begin
            if (exec_uop.dst == s1c88_pkg::DST_A)
                a_reg <= src_val;
            if (exec_uop.dst == s1c88_pkg::DST_BR)
                br_reg <= src_val;
        end
    end

    // operand latches
    always_ff @(posedge clk)
    begin
        if (step_done && exec_uop.dst == s1c88_pkg::DST_AA)
            alu_a <= src_val;
        if (step_done && exec_uop.dst == s1c88_pkg::DST_AB)
            alu_b <= src_val;
    end

endmodule

`default_nettype wire

// ==== cpu/s1c88_bus_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s1c88_settings.svh"

module s1c88_bus_unit
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire s1c88_pkg::bus_req_t      req,
    input  wire logic                     fetching,
    input  wire logic [`S1C88_DATA_W-1:0] data_in,
    output logic                          cycle_end,
    output logic [`S1C88_DATA_W-1:0]      rdata,
    output logic [`S1C88_ADDR_W-1:0]      address_out,
    output logic [`S1C88_DATA_W-1:0]      data_out,
    output s1c88_pkg::bus_cmd_t           bus_status,
    output logic                          read,
    output logic                          write,
    output logic                          sync
);

    logic                     phase;
    logic [`S1C88_DATA_W-1:0] rdata_q;

    // second clock of the machine cycle
    assign cycle_end = phase;

    // live data while the strobe is up, last captured byte otherwise
    assign rdata = read ? data_in : rdata_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase       <= 1'b0;
            address_out <= '1;
            data_out    <= '1;
            bus_status  <= s1c88_pkg::BUS_IDLE;
            read        <= 1'b0;
            write       <= 1'b0;
            sync        <= 1'b0;
        end
        else
        begin
            phase <= ~phase;
            if (!phase)
            begin
                address_out <= req.address;
                bus_status  <= req.cmd;
                if (req.cmd == s1c88_pkg::BUS_MEM_WRITE)
                    data_out <= req.wdata;
                read  <= (req.cmd == s1c88_pkg::BUS_MEM_READ);
                write <= (req.cmd == s1c88_pkg::BUS_MEM_WRITE);
            end
            else
            begin
                read  <= 1'b0;
                write <= 1'b0;
                // sync covers both clocks of the coming fetch cycle
                sync  <= fetching;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (read)
            rdata_q <= data_in;
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

    a_strobe_phase: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> phase);

endmodule

`default_nettype wire

// ==== cpu/s1c88_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s1c88_settings.svh"

module s1c88_sequencer
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     cycle_end,
    input  wire logic [`S1C88_DATA_W-1:0] rdata,
    input  wire logic [`S1C88_DATA_W-1:0] br,
    input  wire logic [`S1C88_DATA_W-1:0] wdata,
    input  wire logic [`S1C88_UPC_W-1:0]  start_uaddr,
    input  wire s1c88_pkg::micro_op_t     uop,
    output logic [`S1C88_DATA_W-1:0]      opcode,
    output logic [`S1C88_UPC_W-1:0]       uaddr,
    output s1c88_pkg::micro_op_t          exec_uop,
    output logic                          step_done,
    output logic [`S1C88_DATA_W-1:0]      imm,
    output s1c88_pkg::bus_req_t           req,
    output logic                          fetching
);

    localparam logic [`S1C88_ADDR_W-1:0] VEC_LO_ADDR = `S1C88_RESET_VECTOR;
    localparam logic [`S1C88_ADDR_W-1:0] VEC_HI_ADDR = `S1C88_RESET_VECTOR + 1;

    typedef enum logic [2:0]
    {
        ST_VEC_LO,
        ST_VEC_HI,
        ST_FETCH,
        ST_IMM,
        ST_EXEC
    } state_t;

    state_t                   state;
    state_t                   state_next;
    logic [`S1C88_PC_W-1:0]   pc;
    logic [`S1C88_DATA_W-1:0] opcode_q;
    logic [`S1C88_DATA_W-1:0] imm_q;
    logic [`S1C88_UPC_W-1:0]  upc;
    logic                     need_imm;
    logic                     pc_read;

    // the opcode is only on rdata during the fetch cycle itself
    assign opcode = (state == ST_FETCH) ? rdata : opcode_q;
    assign need_imm = opcode inside {8'hB4, 8'h44, 8'h45, 8'hDD, 8'hD8, 8'hD9, 8'hDA};

    // a micro step reading at PC consumes another program byte
    assign pc_read = (uop.kind == s1c88_pkg::UOP_RD) && (uop.addr_sel == s1c88_pkg::ADDR_PC);

    assign uaddr = upc;
    assign imm = imm_q;
    assign exec_uop = (state == ST_EXEC) ? uop : '0;
    assign step_done = cycle_end && (state == ST_EXEC);
    assign fetching = (state_next == ST_FETCH);

    always_comb
    begin
        state_next = state;
        if (cycle_end)
        begin
            case (state)
                ST_VEC_LO: state_next = ST_VEC_HI;
                ST_VEC_HI: state_next = ST_FETCH;
                ST_FETCH:  state_next = need_imm ? ST_IMM : ST_EXEC;
                ST_IMM:    state_next = ST_EXEC;
                default:   state_next = uop.last ? ST_FETCH : ST_EXEC;
            endcase
        end
    end

    always_comb
    begin
        req.cmd = s1c88_pkg::BUS_MEM_READ;
        req.address = {{(`S1C88_ADDR_W - `S1C88_PC_W){1'b0}}, pc};
        req.wdata = wdata;
        case (state)
            ST_VEC_LO: req.address = VEC_LO_ADDR;
            ST_VEC_HI: req.address = VEC_HI_ADDR;
            ST_EXEC:
            begin
                case (uop.kind)
                    s1c88_pkg::UOP_RD: req.cmd = s1c88_pkg::BUS_MEM_READ;
                    s1c88_pkg::UOP_WR: req.cmd = s1c88_pkg::BUS_MEM_WRITE;
                    default:           req.cmd = s1c88_pkg::BUS_IDLE;
                endcase
                // page addressing {BR, ll}
                if (uop.addr_sel == s1c88_pkg::ADDR_BRP)
                    req.address = {{(`S1C88_ADDR_W - 2 * `S1C88_DATA_W){1'b0}}, br, imm_q};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= ST_VEC_LO;
            pc    <= '0;
            upc   <= '0;
        end
        else
        begin
            state <= state_next;
            if (cycle_end)
            begin
                case (state)
                    ST_VEC_LO: pc[`S1C88_DATA_W-1:0] <= rdata;
                    ST_VEC_HI: pc[`S1C88_PC_W-1:`S1C88_DATA_W] <= rdata;
                    ST_FETCH,
                    ST_IMM:    pc <= pc + 1'b1;
                    default:
                    begin
                        if (pc_read)
                            pc <= pc + 1'b1;
                    end
                endcase
                if (state_next == ST_EXEC)
                    upc <= (state == ST_EXEC) ? upc + 1'b1 : start_uaddr;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cycle_end && state == ST_FETCH)
            opcode_q <= rdata;
        if (cycle_end && state == ST_IMM)
            imm_q <= rdata;
    end

    a_uaddr_in_rom: assert property (@(posedge clk) disable iff (reset)
        uaddr < `S1C88_UCODE_DEPTH);

    // the bus unit registers req mid cycle, so it must not move before cycle_end
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        !cycle_end |=> $stable(req.cmd));

endmodule

`default_nettype wire

// ==== design/s1c88_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s1c88_settings.svh"

module s1c88_top
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic [`S1C88_DATA_W-1:0] data_in,
    output logic [`S1C88_DATA_W-1:0]      data_out,
    output logic [`S1C88_ADDR_W-1:0]      address_out,
    output s1c88_pkg::bus_cmd_t           bus_status,
    output logic                          read,
    output logic                          write,
    output logic                          sync
);

    s1c88_pkg::bus_req_t       req;
    s1c88_pkg::micro_op_t      uop;
    s1c88_pkg::micro_op_t      exec_uop;
    logic                      cycle_end;
    logic                      step_done;
    logic                      fetching;
    logic [`S1C88_DATA_W-1:0]  rdata;
    logic [`S1C88_DATA_W-1:0]  br;
    logic [`S1C88_DATA_W-1:0]  wdata;
    logic [`S1C88_DATA_W-1:0]  imm;
    logic [`S1C88_DATA_W-1:0]  opcode;
    logic [`S1C88_UPC_W-1:0]   uaddr;
    logic [`S1C88_UPC_W-1:0]   start_uaddr;

    s1c88_sequencer u_sequencer
    (
        .clk(clk),
        .reset(reset),
        .cycle_end(cycle_end),
        .rdata(rdata),
        .br(br),
        .wdata(wdata),
        .start_uaddr(start_uaddr),
        .uop(uop),
        .opcode(opcode),
        .uaddr(uaddr),
        .exec_uop(exec_uop),
        .step_done(step_done),
        .imm(imm),
        .req(req),
        .fetching(fetching)
    );

    s1c88_microcode_rom u_microcode_rom
    (
        .opcode(opcode),
        .uaddr(uaddr),
        .start_uaddr(start_uaddr),
        .uop(uop)
    );

    s1c88_datapath u_datapath
    (
        .clk(clk),
        .reset(reset),
        .exec_uop(exec_uop),
        .step_done(step_done),
        .rdata(rdata),
        .imm(imm),
        .br(br),
        .wdata(wdata)
    );

    s1c88_bus_unit u_bus_unit
    (
        .clk(clk),
        .reset(reset),
        .req(req),
        .fetching(fetching),
        .data_in(data_in),
        .cycle_end(cycle_end),
        .rdata(rdata),
        .address_out(address_out),
        .data_out(data_out),
        .bus_status(bus_status),
        .read(read),
        .write(write),
        .sync(sync)
    );

endmodule

`default_nettype wire

// ==== dv/s1c88_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s1c88_settings.svh"

module s1c88_checker
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     read,
    input  wire logic                     write,
    input  wire logic                     sync,
    input  wire s1c88_pkg::bus_cmd_t      bus_status,
    input  wire logic [`S1C88_ADDR_W-1:0] address_out,
    input  wire logic [`S1C88_DATA_W-1:0] data_out,
    input  wire logic [31:0]              test_num,
    input  wire logic [`S1C88_PC_W-1:0]   vector,
    input  wire logic                     write_expected,
    input  wire logic [`S1C88_ADDR_W-1:0] write_addr,
    input  wire logic [`S1C88_DATA_W-1:0] write_data,
    input  wire logic [`S1C88_PC_W-1:0]   final_fetch,
    output logic                          done,
    output int                            passed,
    output int                            failed
);

    int   errors;
    int   reads_seen;
    logic fetch_seen;
    logic write_seen;
    logic in_reset;

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR test %0d: %s = %h, expected %h", test_num, name, got, exp);
            errors++;
        end
    endtask

    task automatic close_test();
        if (write_expected && !write_seen)
        begin
            $display("test %0d: the write to %h never came before the final fetch",
                     test_num, write_addr);
            errors++;
        end
        if (errors == 0)
        begin
            $display("test %0d passed", test_num);
            passed++;
        end
        else
        begin
            $display("test %0d failed with %0d errors", test_num, errors);
            failed++;
        end
        done = 1'b1;
    endtask

    initial
    begin
        passed = 0;
        failed = 0;
        errors = 0;
        done = 1'b0;
        in_reset = 1'b0;
    end

    // sampled mid clock, away from the edge where the bus unit updates
    always @(negedge clk)
    begin
        if (reset)
        begin
            if (!in_reset)
            begin
                errors = 0;
                reads_seen = 0;
                fetch_seen = 1'b0;
                write_seen = 1'b0;
                done = 1'b0;
            end
            in_reset = 1'b1;
        end
        else
        begin
            // first clock after release, nothing has left reset state yet
            if (in_reset)
            begin
                compare_hex("read", 32'(read), 32'd0);
                compare_hex("write", 32'(write), 32'd0);
                compare_hex("sync", 32'(sync), 32'd0);
                compare_hex("bus_status", 32'(bus_status), 32'(s1c88_pkg::BUS_IDLE));
                compare_hex("data_out", 32'(data_out), 32'hFF);
            end
            in_reset = 1'b0;
            if (!done && write)
            begin
                if (!write_expected || write_seen)
                begin
                    $display("test %0d: unexpected write of %h to address %h",
                             test_num, data_out, address_out);
                    errors++;
                end
                else
                begin
                    compare_hex("address_out", 32'(address_out), 32'(write_addr));
                    compare_hex("data_out", 32'(data_out), 32'(write_data));
                end
                compare_hex("bus_status", 32'(bus_status), 32'(s1c88_pkg::BUS_MEM_WRITE));
                write_seen = 1'b1;
            end
            if (!done && read)
            begin
                // vector low byte then high byte
                if (reads_seen < 2)
                    compare_hex("address_out", 32'(address_out),
                                `S1C88_RESET_VECTOR + reads_seen);
                compare_hex("bus_status", 32'(bus_status), 32'(s1c88_pkg::BUS_MEM_READ));
                reads_seen++;
                if (sync)
                begin
                    if (!fetch_seen)
                        compare_hex("address_out", 32'(address_out), {16'h0000, vector});
                    else if (address_out == {8'h00, final_fetch})
                        close_test();
                    fetch_seen = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_s1c88.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s1c88_settings.svh"

module tb_s1c88;

    localparam int NUM_TESTS = 6;
    localparam int TEST_CYCLES = 200;

    typedef struct packed
    {
        logic [`S1C88_PC_W-1:0]   vector;
        logic [0:7][7:0]          prog;
        logic [3:0]               prog_len;
        logic [15:0]              preset_addr;
        logic [7:0]               preset_data;
        logic                     write_expected;
        logic [`S1C88_ADDR_W-1:0] write_addr;
        logic [7:0]               write_data;
        logic [`S1C88_PC_W-1:0]   final_fetch;
    } test_row_t;

    logic                     clk;
    logic                     reset;
    logic [`S1C88_DATA_W-1:0] data_in;
    logic [`S1C88_DATA_W-1:0] data_out;
    logic [`S1C88_ADDR_W-1:0] address_out;
    s1c88_pkg::bus_cmd_t      bus_status;
    logic                     read;
    logic                     write;
    logic                     sync;

    logic [7:0]  mem [0:65535];
    test_row_t   rows [NUM_TESTS];
    test_row_t   cur;
    logic [31:0] test_num;
    logic        done;
    int          passed;
    int          failed;
    int          timeouts;
    int          wait_cycles;
    int          seed;
    logic [7:0]  m;
    logic [7:0]  nn;

    s1c88_top DUT
    (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_out(data_out),
        .address_out(address_out),
        .bus_status(bus_status),
        .read(read),
        .write(write),
        .sync(sync)
    );

    s1c88_checker u_checker
    (
        .clk(clk),
        .reset(reset),
        .read(read),
        .write(write),
        .sync(sync),
        .bus_status(bus_status),
        .address_out(address_out),
        .data_out(data_out),
        .test_num(test_num),
        .vector(cur.vector),
        .write_expected(cur.write_expected),
        .write_addr(cur.write_addr),
        .write_data(cur.write_data),
        .final_fetch(cur.final_fetch),
        .done(done),
        .passed(passed),
        .failed(failed)
    );

    function automatic test_row_t make_row
    (
        input logic [15:0]     vector,
        input logic [0:7][7:0] prog,
        input logic [3:0]      prog_len,
        input logic [15:0]     preset_addr,
        input logic [7:0]      preset_data,
        input logic            write_expected,
        input logic [23:0]     write_addr,
        input logic [7:0]      write_data
    );
        test_row_t row;
        row.vector = vector;
        row.prog = prog;
        row.prog_len = prog_len;
        row.preset_addr = preset_addr;
        row.preset_data = preset_data;
        row.write_expected = write_expected;
        row.write_addr = write_addr;
        row.write_data = write_data;
        // every program ends with the fetch right after its last byte
        row.final_fetch = vector + {12'h000, prog_len};
        return row;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic load_memory(input test_row_t row);
        for (int a = 0; a < 65536; a++)
            mem[a[15:0]] = 8'h00;
        mem[16'd0] = row.vector[7:0];
        mem[16'd1] = row.vector[15:8];
        for (int i = 0; i < 8; i++)
        begin
            if (i[3:0] < row.prog_len)
                mem[row.vector + i[15:0]] = row.prog[i[2:0]];
        end
        mem[row.preset_addr] = row.preset_data;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory answers on address_out, a little after each rising edge
    always @(posedge clk)
    begin
        #1;
        data_in = mem[address_out[15:0]];
    end

    always @(negedge clk)
    begin
        if (write)
            mem[address_out[15:0]] = data_out;
    end

    initial
    begin
        reset = 1'b1;
        data_in = 8'h00;
        cur = '0;
        test_num = 0;
        timeouts = 0;
        seed = 32'h810c;

        nn = random_byte();
        rows[0] = make_row(16'h0100, {8'hB4, 8'h3A, 8'hDD, 8'h17, nn, 24'h0}, 4'd5,
                           16'hF000, 8'h00, 1'b1, 24'h003A17, nn);
        m = random_byte();
        nn = random_byte();
        rows[1] = make_row(16'h0220, {8'hB4, 8'h41, 8'hD8, 8'h05, nn, 24'h0}, 4'd5,
                           16'h4105, m, 1'b1, 24'h004105, m & nn);
        m = random_byte();
        nn = random_byte();
        rows[2] = make_row(16'h1234, {8'hB4, 8'h52, 8'hD9, 8'h80, nn, 24'h0}, 4'd5,
                           16'h5280, m, 1'b1, 24'h005280, m | nn);
        m = random_byte();
        nn = random_byte();
        rows[3] = make_row(16'h3300, {8'hB4, 8'h60, 8'hDA, 8'hFF, nn, 24'h0}, 4'd5,
                           16'h60FF, m, 1'b1, 24'h0060FF, m ^ nn);
        // load A from one page address, store it to another
        m = random_byte();
        rows[4] = make_row(16'h0400, {8'hB4, 8'h71, 8'h44, 8'h10, 8'h45, 8'h20, 16'h0},
                           4'd6, 16'h7110, m, 1'b1, 24'h007120, m);
        // NOP then an opcode outside the table
        rows[5] = make_row(16'h0500, {8'h00, 8'h77, 48'h0}, 4'd2,
                           16'hF000, 8'h00, 1'b0, 24'h000000, 8'h00);

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            @(posedge clk);
            #1;
            reset = 1'b1;
            test_num = t;
            cur = rows[t];
            load_memory(rows[t]);
            repeat (16) @(posedge clk);
            #1;
            reset = 1'b0;
            wait_cycles = 0;
            while (!done && wait_cycles < TEST_CYCLES)
            begin
                @(posedge clk);
                wait_cycles++;
            end
            if (!done)
            begin
                $display("test %0d: timed out after %0d cycles waiting for the fetch at %h",
                         t, wait_cycles, rows[t].final_fetch);
                timeouts++;
            end
        end

        $display("tests run %0d, passed %0d, failed %0d", NUM_TESTS, passed,
                 failed + timeouts);
        if (failed + timeouts == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/s1c88_pkg.sv
cpu/s1c88_microcode_rom.sv
cpu/s1c88_datapath.sv
cpu/s1c88_bus_unit.sv
cpu/s1c88_sequencer.sv
design/s1c88_top.sv
dv/s1c88_checker.sv
dv/tb_s1c88.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_s1c88
FILELIST = filelist.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
